/* all.f */
+incdir+verilog
verilog/rw_mem_pkg.sv
verilog/rw_engine_pkg.sv
verilog/rw_sync_fifo.sv
verilog/rw_gen_control.sv
verilog/rw_gen_kernel.sv
verilog/rw_gen_top.sv
tb/rw_gen_chk.sv
tb/rw_gen_tb.sv

/* Makefile */
# Verilator lint, simulation and clean for the read/write generator

TOP := rw_gen_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

# Pass only if the log holds the pass line
sim:
	verilator --binary --timing --assert -Wno-fatal -j 0 -f all.f --top-module $(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+10 | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb/rw_gen_tb.sv */
// --------------------------------------------------
// Testbench for the read/write generator: clock and
// reset, LFSR stimulus, reference model, request
// monitor, compare tasks and watchdog
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module rw_gen_tb;

    localparam int total_items = 12 + 48 + 10 + 9 + 14;
    localparam int total_txns  = 6;
    localparam int max_cycles  = total_items * 40 + 2000;

    logic                      ap_clk = 1'b0;
    logic                      areset;
    logic                      config_valid;
    rw_engine_pkg::rw_config_t config_in;
    logic                      data_valid = 1'b0;
    rw_mem_pkg::data_t         data_in = '0;
    logic                      data_ready;
    logic                      request_ready = 1'b1;
    logic                      request_valid;
    rw_mem_pkg::request_t      request_out;
    logic                      busy;
    logic                      done;

    logic [15:0]               lfsr = 16'd76;
    rw_mem_pkg::data_t         send_q[$];
    rw_mem_pkg::data_t         word_q[$];
    rw_engine_pkg::rw_config_t cur_cfg = '0;
    rw_engine_pkg::count_t     item_idx = '0;
    logic                      txn_active = 1'b0;
    logic                      ready_seen = 1'b0;
    logic                      ready_fell = 1'b0;
    logic                      prev_req = 1'b0;
    int                        done_count = 0;
    int                        ready_mode = 0;
    int                        prev_mode = 0;
    int                        ready_hold = 0;

    rw_gen_top dut_i (
        .ap_clk       (ap_clk),
        .areset       (areset),
        .config_valid (config_valid),
        .config_in    (config_in),
        .data_valid   (data_valid),
        .data_in      (data_in),
        .data_ready   (data_ready),
        .request_ready(request_ready),
        .request_valid(request_valid),
        .request_out  (request_out),
        .busy         (busy),
        .done         (done)
    );

    bind rw_gen_top rw_gen_chk chk_i (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .request_valid   (request_valid),
        .busy            (busy),
        .done            (done)
    );

    always #50 ap_clk = ~ap_clk;

    // --------------------------------------------------
    // Random source and reference model
    // --------------------------------------------------
    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic rw_engine_pkg::rw_config_t make_config(
        input rw_engine_pkg::count_t count
    );
        rw_engine_pkg::rw_config_t cfg;
        cfg.base_addr = take_bits(32);
        cfg.stride    = rw_mem_pkg::addr_t'(take_bits(12));
        cfg.count     = count;
        cfg.incr      = take_bits(32);
        cfg.tag       = rw_mem_pkg::tag_t'(take_bits(8));
        return cfg;
    endfunction

    // Expected request for item k from the configuration and its input word
    function automatic rw_mem_pkg::request_t expected_request(
        input rw_engine_pkg::rw_config_t cfg,
        input rw_engine_pkg::count_t     k,
        input rw_mem_pkg::data_t         word
    );
        rw_mem_pkg::request_t r;
        r.addr = cfg.base_addr + rw_mem_pkg::addr_t'(k) * cfg.stride;
        r.data = word + cfg.incr;
        r.tag  = cfg.tag;
        return r;
    endfunction

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic fail_now(input string msg);
        $display("ERROR at time %0t: %s", $time, msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_request(input rw_mem_pkg::request_t got,
                                   input rw_mem_pkg::request_t exp,
                                   input rw_engine_pkg::count_t k);
        if (got !== exp) begin
            fail_now($sformatf("request %0d got %h/%h/%h, expected %h/%h/%h", k,
                               got.addr, got.data, got.tag, exp.addr, exp.data, exp.tag));
        end
    endtask

    task automatic compare_count(input rw_engine_pkg::count_t got,
                                 input rw_engine_pkg::count_t exp);
        if (got !== exp) begin
            fail_now($sformatf("%0d requests before done, expected %0d", got, exp));
        end
    endtask

    task automatic compare_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_now($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    // --------------------------------------------------
    // Drivers
    // --------------------------------------------------
    // At most one word every other cycle so data_ready is never stale
    always @(posedge ap_clk) begin : word_driver
        rw_mem_pkg::data_t w;
        if (send_q.size() > 0 && ready_seen && !data_valid) begin
            w = send_q.pop_front();
            word_q.push_back(w);
            data_valid <= 1'b1;
            data_in    <= w;
        end else begin
            data_valid <= 1'b0;
        end
    end

    always @(posedge ap_clk) begin : ready_driver
        if (ready_mode == 0) begin
            request_ready <= 1'b1;
        end else if (prev_mode == 0) begin
            // Long stall first so both buffers back up
            request_ready <= 1'b0;
            ready_hold = 80;
        end else if (ready_hold > 0) begin
            ready_hold = ready_hold - 1;
        end else if (request_ready) begin
            request_ready <= 1'b0;
            ready_hold = 8 + int'(take_bits(5));
        end else begin
            request_ready <= 1'b1;
            ready_hold = int'(take_bits(3));
        end
        prev_mode = ready_mode;
    end

    // --------------------------------------------------
    // Monitor
    // --------------------------------------------------
    always @(negedge ap_clk) begin : monitor
        rw_mem_pkg::request_t exp;
        if (dut_i.chk_i.fail_count != 0) begin
            fail_now("a protocol assertion in the bound checker failed");
        end
        ready_seen = data_ready;
        if (!data_ready) begin
            ready_fell = 1'b1;
        end
        if (request_valid) begin
            if (!txn_active || item_idx >= cur_cfg.count || word_q.size() == 0) begin
                fail_now("request outside a transaction or beyond its count");
            end
            exp = expected_request(cur_cfg, item_idx, word_q.pop_front());
            compare_request(request_out, exp, item_idx);
            item_idx = item_idx + rw_engine_pkg::count_t'(1);
        end
        if (done) begin
            if (!txn_active || busy) begin
                fail_now("done pulse outside a transaction or together with busy");
            end
            compare_count(item_idx, cur_cfg.count);
            if (cur_cfg.count != 0 && !prev_req) begin
                fail_now("done did not follow the last request by one cycle");
            end
            txn_active = 1'b0;
            done_count = done_count + 1;
        end
        prev_req = request_valid;
    end

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic run_transaction(input rw_engine_pkg::count_t count, input int n_words);
        rw_engine_pkg::rw_config_t cfg;
        @(negedge ap_clk);
        cfg = make_config(count);
        for (int i = 0; i < n_words; i++) begin
            send_q.push_back(take_bits(32));
        end
        @(posedge ap_clk);
        config_valid <= 1'b1;
        config_in    <= cfg;
        cur_cfg    = cfg;
        item_idx   = '0;
        txn_active = 1'b1;
        @(posedge ap_clk);
        config_valid <= 1'b0;
        // One cycle in START before BUSY
        @(negedge ap_clk);
        compare_level(busy, 1'b0, "busy in START");
        @(negedge ap_clk);
        compare_level(busy, count != 0, "busy after START");
        while (txn_active) begin
            @(negedge ap_clk);
        end
        @(negedge ap_clk);
        compare_level(busy, 1'b0, "busy after done");
    endtask

    initial begin : main
        areset       = 1'b1;
        config_valid = 1'b0;
        config_in    = '0;
        repeat (4) @(posedge ap_clk);
        areset <= 1'b0;

        // Levels right after reset
        repeat (4) begin
            @(negedge ap_clk);
            compare_level(busy, 1'b0, "busy after reset");
            compare_level(done, 1'b0, "done after reset");
            compare_level(request_valid, 1'b0, "request_valid after reset");
            compare_level(data_ready, 1'b1, "data_ready after reset");
        end

        run_transaction(12, 12);

        // Random back-pressure with long stalls
        ready_mode = 1;
        run_transaction(48, 48);
        compare_level(ready_fell, 1'b1, "data_ready fell under back-pressure");
        ready_mode = 0;

        // Words queued while idle go to the next transaction
        for (int i = 0; i < 6; i++) begin
            send_q.push_back(take_bits(32));
        end
        while (send_q.size() > 0) begin
            @(negedge ap_clk);
        end
        repeat (4) @(negedge ap_clk);
        run_transaction(10, 4);

        // Three words carry over from the first into the second
        run_transaction(9, 12);
        run_transaction(14, 11);

        run_transaction(0, 0);

        repeat (4) @(negedge ap_clk);
        if (done_count == total_txns && word_q.size() == 0 && send_q.size() == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("Wrong number of done pulses, or input words left unused");
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (max_cycles) @(posedge ap_clk);
        $display("Timeout: the run did not finish within %0d clock cycles", max_cycles);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule : rw_gen_tb

`default_nettype wire

/* tb/rw_gen_chk.sv */
// --------------------------------------------------
// Protocol assertions for the generator top: done
// width, no request strobe in reset, busy and done
// never together
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module rw_gen_chk (
    input logic ap_clk,
    input logic areset_generator,
    input logic request_valid,
    input logic busy,
    input logic done
);

    // Count of failed assertions
    int fail_count = 0;

    done_one_cycle: assert property (
        @(posedge ap_clk) disable iff (areset_generator) done |=> !done
    ) else begin
        $error("done held for more than one cycle");
        fail_count = fail_count + 1;
    end

    no_request_in_reset: assert property (
        @(posedge ap_clk) areset_generator |-> !request_valid
    ) else begin
        $error("request_valid high during reset");
        fail_count = fail_count + 1;
    end

    busy_done_exclusive: assert property (
        @(posedge ap_clk) disable iff (areset_generator) !(busy && done)
    ) else begin
        $error("busy and done high together");
        fail_count = fail_count + 1;
    end

endmodule : rw_gen_chk

`default_nettype wire

/* verilog/rw_gen_top.sv */
// --------------------------------------------------
// Read/write generator top: input buffer, kernel,
// output buffer and controller
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "rw_gen_settings.svh"

module rw_gen_top (
    input  logic                      ap_clk,
    input  logic                      areset,
    input  logic                      config_valid,
    input  rw_engine_pkg::rw_config_t config_in,
    input  logic                      data_valid,
    input  rw_mem_pkg::data_t         data_in,
    output logic                      data_ready,
    input  logic                      request_ready,
    output logic                      request_valid,
    output rw_mem_pkg::request_t      request_out,
    output logic                      busy,
    output logic                      done
);

    logic areset_generator;

    logic                 in_pop;
    logic                 in_full;
    logic                 in_empty;
    logic                 word_valid;
    rw_mem_pkg::data_t    word;
    logic                 req_valid;
    rw_mem_pkg::request_t req;
    logic                 out_pop;
    logic                 out_empty;
    logic                 prog_full;
    logic                 config_load;
    logic                 accept_enable;

    always_ff @(posedge ap_clk) begin
        areset_generator <= areset;
    end

    assign data_ready = ~in_full;
    assign in_pop     = accept_enable & ~in_empty;
    assign out_pop    = request_ready & ~out_empty;

    // --------------------------------------------------
    // Pipeline
    // --------------------------------------------------
    rw_sync_fifo #(
        .payload_t(rw_mem_pkg::data_t),
        .depth    (`RW_FIFO_DEPTH)
    ) input_fifo_i (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .push            (data_valid),
        .push_data       (data_in),
        .pop             (in_pop),
        .pop_data        (word),
        .pop_valid       (word_valid),
        .full            (in_full),
        .empty           (in_empty),
        .prog_full       ()
    );

    rw_gen_kernel kernel_i (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .config_load     (config_load),
        .config_in       (config_in),
        .word_valid      (word_valid),
        .word            (word),
        .req_valid       (req_valid),
        .req             (req)
    );

    rw_sync_fifo #(
        .payload_t(rw_mem_pkg::request_t),
        .depth    (`RW_FIFO_DEPTH)
    ) output_fifo_i (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .push            (req_valid),
        .push_data       (req),
        .pop             (out_pop),
        .pop_data        (request_out),
        .pop_valid       (request_valid),
        .full            (),
        .empty           (out_empty),
        .prog_full       (prog_full)
    );

    // Each request strobe retires one outstanding item
    rw_gen_control control_i (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .config_valid    (config_valid),
        .config_count    (config_in.count),
        .prog_full       (prog_full),
        .request_sent    (request_valid),
        .word_accepted   (in_pop),
        .config_load     (config_load),
        .accept_enable   (accept_enable),
        .busy            (busy),
        .done            (done)
    );

endmodule : rw_gen_top

`default_nettype wire

/* verilog/rw_gen_kernel.sv */
// --------------------------------------------------
// Address and data computation, one registered
// request per accepted input word
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module rw_gen_kernel (
    input  logic                      ap_clk,
    input  logic                      areset_generator,
    input  logic                      config_load,
    input  rw_engine_pkg::rw_config_t config_in,
    input  logic                      word_valid,
    input  rw_mem_pkg::data_t         word,
    output logic                      req_valid,
    output rw_mem_pkg::request_t      req
);

    rw_engine_pkg::rw_config_t cfg_q;

    // Running address of the next item
    rw_mem_pkg::addr_t next_addr;

    // --------------------------------------------------
    // Configuration and item address
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (config_load) begin
            cfg_q     <= config_in;
            next_addr <= config_in.base_addr;
        end else if (word_valid) begin
            next_addr <= next_addr + cfg_q.stride;
        end
    end

    // --------------------------------------------------
    // Request register
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (word_valid) begin
            req.addr <= next_addr;
            req.data <= word + cfg_q.incr;
            req.tag  <= cfg_q.tag;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= word_valid;
        end
    end

endmodule : rw_gen_kernel

`default_nettype wire

/* verilog/rw_gen_control.sv */
// --------------------------------------------------
// Transaction FSM with pause on back-pressure,
// released-word count and outstanding-request
// down counter
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module rw_gen_control (
    input  logic                  ap_clk,
    input  logic                  areset_generator,
    input  logic                  config_valid,
    input  rw_engine_pkg::count_t config_count,
    input  logic                  prog_full,
    input  logic                  request_sent,
    input  logic                  word_accepted,
    output logic                  config_load,
    output logic                  accept_enable,
    output logic                  busy,
    output logic                  done
);

    rw_engine_pkg::gen_state_t state;
    rw_engine_pkg::gen_state_t next_state;

    rw_engine_pkg::count_t count_q;
    rw_engine_pkg::count_t remaining;
    rw_engine_pkg::count_t released;
    logic                  last_request;

    // Configuration only taken while idle
    assign config_load = (state == rw_engine_pkg::IDLE) & config_valid;

    // Final request of the transaction leaves this cycle
    assign last_request = request_sent & (remaining == rw_engine_pkg::count_t'(1));

    // --------------------------------------------------
    // State machine
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= rw_engine_pkg::RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            rw_engine_pkg::RESET: next_state = rw_engine_pkg::IDLE;
            rw_engine_pkg::IDLE: begin
                if (config_valid) next_state = rw_engine_pkg::START;
            end
            rw_engine_pkg::START: begin
                // Empty transaction skips straight to the pulse
                if (count_q == '0) next_state = rw_engine_pkg::DONE;
                else next_state = rw_engine_pkg::BUSY;
            end
            rw_engine_pkg::BUSY: begin
                if (last_request) next_state = rw_engine_pkg::DONE;
                else if (prog_full) next_state = rw_engine_pkg::PAUSE;
            end
            rw_engine_pkg::PAUSE: begin
                if (last_request) next_state = rw_engine_pkg::DONE;
                else if (!prog_full) next_state = rw_engine_pkg::BUSY;
            end
            rw_engine_pkg::DONE: next_state = rw_engine_pkg::IDLE;
            default: next_state = rw_engine_pkg::RESET;
        endcase
    end

    // --------------------------------------------------
    // Counters
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            count_q   <= '0;
            remaining <= '0;
            released  <= '0;
        end else begin
            if (config_load) begin
                count_q <= config_count;
            end
            if (state == rw_engine_pkg::START) begin
                remaining <= count_q;
                released  <= '0;
            end else begin
                if (request_sent && remaining != '0) begin
                    remaining <= remaining - 1'b1;
                end
                if (word_accepted) begin
                    released <= released + 1'b1;
                end
            end
        end
    end

    // Never release more words than the transaction asks for
    assign accept_enable = (state == rw_engine_pkg::BUSY) && (released < count_q);

    assign busy = (state == rw_engine_pkg::BUSY) || (state == rw_engine_pkg::PAUSE);
    assign done = (state == rw_engine_pkg::DONE);

endmodule : rw_gen_control

`default_nettype wire

/* verilog/rw_sync_fifo.sv */
// --------------------------------------------------
// Synchronous FIFO with registered read, typed
// payload and nearly-full flag
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "rw_gen_settings.svh"

module rw_sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 16
) (
    input  logic     ap_clk,
    input  logic     areset_generator,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     pop_valid,
    output logic     full,
    output logic     empty,
    output logic     prog_full
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t mem [depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] fill;
    logic             do_push;
    logic             do_pop;

    // Requests on a full or empty buffer are dropped here
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    assign full      = (fill == cnt_w'(depth));
    assign empty     = (fill == '0);
    assign prog_full = (fill >= cnt_w'(`RW_PROG_THRESH));

    // --------------------------------------------------
    // Pointers and fill level
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            fill      <= '0;
            pop_valid <= 1'b0;
        end else begin
            pop_valid <= do_pop;
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // Storage and registered read port
    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
        if (do_pop) begin
            pop_data <= mem[rd_ptr];
        end
    end

endmodule : rw_sync_fifo

`default_nettype wire

/* verilog/rw_engine_pkg.sv */
// --------------------------------------------------
// Engine control types: item count, transaction
// parameters and controller states
// --------------------------------------------------

`default_nettype none

`include "rw_gen_settings.svh"

package rw_engine_pkg;

    typedef logic [`RW_COUNT_W-1:0] count_t;

    // --------------------------------------------------
    // Transaction parameters
    // --------------------------------------------------
    typedef struct packed {
        rw_mem_pkg::addr_t base_addr;
        rw_mem_pkg::addr_t stride;
        count_t            count;
        rw_mem_pkg::data_t incr;
        rw_mem_pkg::tag_t  tag;
    } rw_config_t;

    // --------------------------------------------------
    // Controller states
    // --------------------------------------------------
    typedef enum logic [2:0] {
        RESET,
        IDLE,
        START,
        BUSY,
        PAUSE,
        DONE
    } gen_state_t;

endpackage : rw_engine_pkg

`default_nettype wire

/* verilog/rw_mem_pkg.sv */
// --------------------------------------------------
// Memory side types: data word, address, tag
// and the outgoing request payload
// --------------------------------------------------

`default_nettype none

`include "rw_gen_settings.svh"

package rw_mem_pkg;

    // --------------------------------------------------
    // Basic fields
    // --------------------------------------------------
    typedef logic [`RW_DATA_W-1:0] data_t;

    typedef logic [`RW_ADDR_W-1:0] addr_t;

    // Carried unchanged from the configuration
    typedef logic [`RW_TAG_W-1:0] tag_t;

    // --------------------------------------------------
    // Request payload
    // --------------------------------------------------
    // Address in the upper bits, tag at the bottom
    typedef struct packed {
        addr_t addr;
        data_t data;
        tag_t  tag;
    } request_t;

endpackage : rw_mem_pkg

`default_nettype wire

/* verilog/rw_gen_settings.svh */
// --------------------------------------------------
// Widths, buffer depth and nearly-full threshold
// for the read/write generator
// --------------------------------------------------

`ifndef RW_GEN_SETTINGS_SVH
`define RW_GEN_SETTINGS_SVH

// --------------------------------------------------
// Memory side widths
// --------------------------------------------------
`define RW_DATA_W 32
`define RW_ADDR_W 32
`define RW_TAG_W 8

// Item count per transaction
`define RW_COUNT_W 16

// --------------------------------------------------
// Buffers
// --------------------------------------------------
`define RW_FIFO_DEPTH 16

// Fill level that stops input; leaves room for words in flight
`define RW_PROG_THRESH 8

`endif
